// File: thor_alu_config.svh
// data width, opcode and function code encodings, bad-op fill word
`ifndef THOR_ALU_CONFIG_SVH
`define THOR_ALU_CONFIG_SVH

// ==============================
// data path
// ==============================
`define THOR_DBW		64

// ==============================
// opcodes (8 bits)
// ==============================
`define TST			8'h00	// integer test, fn selects kind
`define CMP			8'h10	// register compare
`define CMPI		8'h20	// compare with immediate
`define RR			8'h40	// register-register arithmetic
`define LOGIC		8'h42	// register logic group
`define ADDI		8'h48
`define SUBI		8'h49
`define ANDI		8'h4C
`define ORI			8'h4D
`define EORI		8'h4E
`define R			8'h50	// unary group
`define SHIFT		8'h58
`define _2ADDUI		8'h6B	// scaled adds with immediate
`define _4ADDUI		8'h6C
`define _8ADDUI		8'h6D
`define _16ADDUI	8'h6E
`define LDI			8'h6F
`define MUX			8'h72
`define JSR			8'hA2	// link value only
`define INT			8'hA6
`define BITFIELD	8'hAA
`define BCD			8'hF6

// ==============================
// function codes (6 bits)
// ==============================
// RR group
`define ADD			6'd0
`define SUB			6'd1
`define _2ADDU		6'd4
`define _4ADDU		6'd5
`define _8ADDU		6'd6
`define _16ADDU		6'd7
`define MIN			6'd20	// unsigned
`define MAX			6'd21	// unsigned
// R group
`define MOV			6'd0
`define NEG			6'd1
`define NOT			6'd2
`define ABS			6'd3
`define SGN			6'd4
// LOGIC group
`define AND			6'd0
`define OR			6'd1
`define EOR			6'd2
`define NAND		6'd3
`define NOR			6'd4
`define ENOR		6'd5
`define ANDC		6'd6
`define ORC			6'd7
// TST group
`define ITST		6'd0	// integer test
// BCD group
`define BCDADD		6'd0
`define BCDSUB		6'd1
`define BCDMUL		6'd2
// SHIFT group
`define SHL			6'd0
`define SHR			6'd1
`define ROL			6'd2
`define ROR			6'd3
`define ASR			6'd4
// BITFIELD group
`define BFSET		6'd0
`define BFCLR		6'd1
`define BFCHG		6'd2
`define BFEXTU		6'd4

// returned for an opcode the stage does not know
`define THOR_BADOP	64'hDEADDEADDEADDEAD

`endif

// File: thor_alu_pkg.sv
// word, immediate union and flag result types for the execute stage
`include "thor_alu_config.svh"

package thor_alu_pkg;

	// plain data word
	typedef logic [`THOR_DBW-1:0] thor_word_t;

	// bitfield view of the immediate, low 12 bits carry the range
	typedef struct packed {
		logic [51:0] rsvd;		// ignored by bitfield ops
		logic [5:0] me;			// mask end, inclusive
		logic [5:0] mb;			// mask begin
	} thor_bf_spec_t;

	// immediate, read as a word or as a bitfield spec
	typedef union packed {
		thor_word_t word;
		thor_bf_spec_t bf;
	} thor_imm_u;

	// compare / test result, bit 0 upward
	typedef struct packed {
		logic [59:0] zero;		// always 0
		logic nan;				// unordered, unused for integers
		logic ltu;				// unsigned less
		logic lt;				// signed less
		logic eq;
	} thor_flags_t;

endpackage

// File: thor_alu_if.sv
// operand and result bundle between the execute stage and the ALU
`timescale 1ns/1ps

interface thor_alu_if;

	logic [7:0] op;							// opcode
	logic [5:0] fn;							// function code
	thor_alu_pkg::thor_word_t arg_a;
	thor_alu_pkg::thor_word_t arg_b;
	thor_alu_pkg::thor_word_t arg_c;		// mux false source
	thor_alu_pkg::thor_imm_u arg_i;			// immediate / bitfield spec
	thor_alu_pkg::thor_word_t pc;
	logic [3:0] insnsz;						// instruction length
	thor_alu_pkg::thor_word_t result;

	// stage side, feeds operands in
	modport stage (
		output op, fn, arg_a, arg_b, arg_c, arg_i, pc, insnsz,
		input result
	);

	// ALU side
	modport alu (
		input op, fn, arg_a, arg_b, arg_c, arg_i, pc, insnsz,
		output result
	);

endinterface

// File: thor_shifter.sv
// shifter unit, logical and arithmetic shifts plus rotates
`timescale 1ns/1ps
`include "thor_alu_config.svh"

module thor_shifter (
	input logic [5:0] fn,
	input thor_alu_pkg::thor_word_t a,
	input logic [5:0] amt,			// shift count 0..63
	output thor_alu_pkg::thor_word_t o
);

	logic [127:0] dbl;				// a doubled up for rotates
	logic [127:0] rol_w;
	logic [127:0] ror_w;

	assign dbl = {a, a};
	assign rol_w = dbl << amt;		// upper half is the rotated word
	assign ror_w = dbl >> amt;		// lower half is the rotated word

	always_comb
	begin
		case (fn)
		`SHL:
		begin
			o = a << amt;
		end
		`SHR:
		begin
			o = a >> amt;			// zero fill
		end
		`ASR:
		begin
			o = $signed(a) >>> amt;	// sign fill
		end
		`ROL:
		begin
			o = rol_w[127:64];
		end
		`ROR:
		begin
			o = ror_w[63:0];
		end
		default:
		begin
			o = '0;					// not a shift
		end
		endcase
	end

endmodule

// File: thor_bcd_unit.sv
// two digit packed BCD add, subtract and multiply
`timescale 1ns/1ps
`include "thor_alu_config.svh"

module thor_bcd_unit (
	input logic [5:0] fn,
	input logic [7:0] a,			// two packed digits
	input logic [7:0] b,
	output logic [15:0] o			// four digits for multiply
);

	// one digit add, bit 4 is carry out
	function automatic logic [4:0] dig_add(input logic [3:0] x, input logic [3:0] y,
		input logic ci);
		logic [4:0] s;
		s = {1'b0, x} + {1'b0, y} + {4'd0, ci};
		if (s > 5'd9)
			s = s + 5'd6;			// decimal adjust, carry lands in bit 4
		return s;
	endfunction

	// one digit subtract, bit 4 is borrow out
	function automatic logic [4:0] dig_sub(input logic [3:0] x, input logic [3:0] y,
		input logic bi);
		logic [4:0] d;
		d = {1'b0, x} - {1'b0, y} - {4'd0, bi};
		if (d[4])
			d = d - 5'd6;			// wrap digit back into 0..9
		return d;
	endfunction

	// binary to four BCD digits, shift-add-3
	function automatic logic [15:0] bin_to_bcd(input logic [13:0] bin);
		logic [15:0] bcd;
		int i;
		bcd = '0;
		for (i = 13; i >= 0; i--)
		begin
			if (bcd[3:0] > 4'd4) bcd[3:0] = bcd[3:0] + 4'd3;
			if (bcd[7:4] > 4'd4) bcd[7:4] = bcd[7:4] + 4'd3;
			if (bcd[11:8] > 4'd4) bcd[11:8] = bcd[11:8] + 4'd3;
			if (bcd[15:12] > 4'd4) bcd[15:12] = bcd[15:12] + 4'd3;
			bcd = {bcd[14:0], bin[i]};
		end
		return bcd;
	endfunction

	logic [4:0] add_lo, add_hi;
	logic [4:0] sub_lo, sub_hi;
	logic [6:0] a_bin, b_bin;		// 0..99
	logic [13:0] prod;				// up to 9801

	// ripple through the two digits, no carry in
	assign add_lo = dig_add(a[3:0], b[3:0], 1'b0);
	assign add_hi = dig_add(a[7:4], b[7:4], add_lo[4]);	// carry out dropped
	assign sub_lo = dig_sub(a[3:0], b[3:0], 1'b0);
	assign sub_hi = dig_sub(a[7:4], b[7:4], sub_lo[4]);	// borrow out dropped

	// multiply goes through binary
	assign a_bin = {3'd0, a[7:4]} * 7'd10 + {3'd0, a[3:0]};
	assign b_bin = {3'd0, b[7:4]} * 7'd10 + {3'd0, b[3:0]};
	assign prod = {7'd0, a_bin} * {7'd0, b_bin};

	always_comb
	begin
		case (fn)
		`BCDADD:	o = {8'd0, add_hi[3:0], add_lo[3:0]};
		`BCDSUB:	o = {8'd0, sub_hi[3:0], sub_lo[3:0]};
		`BCDMUL:	o = bin_to_bcd(prod);
		default:	o = '0;
		endcase
	end

endmodule

// File: thor_bitfield.sv
// bitfield mask generation with set, clear, change and extract
`timescale 1ns/1ps
`include "thor_alu_config.svh"

module thor_bitfield (
	input logic [5:0] fn,
	input thor_alu_pkg::thor_word_t a,
	input thor_alu_pkg::thor_bf_spec_t spec,	// mb / me from the immediate
	output thor_alu_pkg::thor_word_t o
);

	thor_alu_pkg::thor_word_t mask;
	thor_alu_pkg::thor_word_t field;

	// ==============================
	// mask, ones from mb up to me
	// ==============================
	always_comb
	begin
		for (int i = 0; i < `THOR_DBW; i++)
		begin
			// empty when mb > me
			mask[i] = (i[5:0] >= spec.mb) && (i[5:0] <= spec.me);
		end
	end

	assign field = a & mask;

	// ==============================
	// operation select
	// ==============================
	always_comb
	begin
		case (fn)
		`BFSET:
		begin
			o = a | mask;
		end
		`BFCLR:
		begin
			o = a & ~mask;
		end
		`BFCHG:
		begin
			o = a ^ mask;			// flip the range
		end
		`BFEXTU:
		begin
			o = field >> spec.mb;	// right justify, zero extend
		end
		default:
		begin
			o = '0;
		end
		endcase
	end

endmodule

// File: thor_alu.sv
// integer ALU, opcode and function decode with result select
`timescale 1ns/1ps
`include "thor_alu_config.svh"

module thor_alu (
	thor_alu_if.alu bus
);

	thor_alu_pkg::thor_word_t a, b, c, imm;
	thor_alu_pkg::thor_word_t res;
	thor_alu_pkg::thor_word_t shft_o;
	thor_alu_pkg::thor_word_t bf_o;
	logic [15:0] bcd_o;
	thor_alu_pkg::thor_flags_t cmp_flags;
	thor_alu_pkg::thor_flags_t cmpi_flags;
	thor_alu_pkg::thor_flags_t tst_flags;

	assign a = bus.arg_a;
	assign b = bus.arg_b;
	assign c = bus.arg_c;
	assign imm = bus.arg_i.word;		// plain word view

	// ==============================
	// sub units
	// ==============================
	thor_shifter u_shifter (
		.fn(bus.fn),
		.a(a),
		.amt(b[5:0]),					// count from arg b
		.o(shft_o)
	);

	thor_bcd_unit u_bcd (
		.fn(bus.fn),
		.a(a[7:0]),
		.b(b[7:0]),
		.o(bcd_o)
	);

	thor_bitfield u_bf (
		.fn(bus.fn),
		.a(a),
		.spec(bus.arg_i.bf),			// mask range view of the immediate
		.o(bf_o)
	);

	// ==============================
	// flag words
	// ==============================
	always_comb
	begin
		cmp_flags = '0;
		cmp_flags.eq = (a == b);
		cmp_flags.lt = ($signed(a) < $signed(b));
		cmp_flags.ltu = (a < b);

		cmpi_flags = '0;
		cmpi_flags.eq = (a == imm);
		cmpi_flags.lt = ($signed(a) < $signed(imm));
		cmpi_flags.ltu = (a < imm);

		tst_flags = '0;
		tst_flags.eq = (a == '0);
		tst_flags.lt = a[63];			// sign bit only, ltu stays 0
	end

	// ==============================
	// opcode first, fn second
	// ==============================
	always_comb
	begin
		case (bus.op)
		`LDI:		res = imm;
		`RR:
		begin
			case (bus.fn)
			`ADD:		res = a + b;
			`SUB:		res = a - b;
			`_2ADDU:	res = {a[62:0], 1'b0} + b;
			`_4ADDU:	res = {a[61:0], 2'b0} + b;
			`_8ADDU:	res = {a[60:0], 3'b0} + b;
			`_16ADDU:	res = {a[59:0], 4'b0} + b;
			`MIN:		res = (a < b) ? a : b;
			`MAX:		res = (a < b) ? b : a;
			default:	res = '0;
			endcase
		end
		`_2ADDUI:	res = {a[62:0], 1'b0} + imm;
		`_4ADDUI:	res = {a[61:0], 2'b0} + imm;
		`_8ADDUI:	res = {a[60:0], 3'b0} + imm;
		`_16ADDUI:	res = {a[59:0], 4'b0} + imm;
		`R:
		begin
			case (bus.fn)
			`MOV:		res = a;
			`NEG:		res = -a;
			`NOT:		res = ~a;
			`ABS:		res = a[63] ? -a : a;
			`SGN:		res = a[63] ? '1 : ((a == '0) ? '0 : 64'd1);
			default:	res = `THOR_BADOP;	// unary group flags bad fn
			endcase
		end
		`ADDI:		res = a + imm;
		`SUBI:		res = a - imm;
		`ANDI:		res = a & imm;
		`ORI:		res = a | imm;
		`EORI:		res = a ^ imm;
		`LOGIC:
		begin
			case (bus.fn)
			`AND:		res = a & b;
			`ANDC:		res = a & ~b;
			`OR:		res = a | b;
			`ORC:		res = a | ~b;
			`EOR:		res = a ^ b;
			`NAND:		res = ~(a & b);
			`NOR:		res = ~(a | b);
			`ENOR:		res = ~(a ^ b);
			default:	res = '0;
			endcase
		end
		`TST:		res = (bus.fn == `ITST) ? tst_flags : '0;
		`CMP:		res = cmp_flags;
		`CMPI:		res = cmpi_flags;
		`MUX:		res = (a & b) | (~a & c);		// per bit, a picks b
		`JSR:		res = bus.pc + {60'd0, bus.insnsz};	// return address
		`INT:		res = bus.pc;
		`BCD:		res = {48'd0, bcd_o};		// unit zeroes bad fn
		`SHIFT:		res = shft_o;
		`BITFIELD:	res = bf_o;
		default:	res = `THOR_BADOP;
		endcase
	end

	assign bus.result = res;

endmodule

// File: thor_alu_stage.sv
// execute stage top, ALU plus result and valid registers
`timescale 1ns/1ps

module thor_alu_stage (
	input logic clk,
	input logic rst_n,
	input logic issue,						// one op this cycle
	input logic [7:0] op,
	input logic [5:0] fn,
	input thor_alu_pkg::thor_word_t arg_a,
	input thor_alu_pkg::thor_word_t arg_b,
	input thor_alu_pkg::thor_word_t arg_c,
	input thor_alu_pkg::thor_word_t arg_i,
	input thor_alu_pkg::thor_word_t pc,
	input logic [3:0] insnsz,
	output thor_alu_pkg::thor_word_t result,
	output logic result_valid				// one cycle after issue
);

	thor_alu_if u_bus ();

	// plain ports onto the operand bundle
	assign u_bus.op = op;
	assign u_bus.fn = fn;
	assign u_bus.arg_a = arg_a;
	assign u_bus.arg_b = arg_b;
	assign u_bus.arg_c = arg_c;
	assign u_bus.arg_i.word = arg_i;
	assign u_bus.pc = pc;
	assign u_bus.insnsz = insnsz;

	thor_alu u_alu (
		.bus(u_bus.alu)
	);

	// capture on issue, hold otherwise
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			result <= '0;
			result_valid <= 1'b0;
		end
		else
		begin
			result_valid <= issue;		// single cycle pulse per issue
			if (issue)
				result <= u_bus.result;
		end
	end

endmodule

// File: tb_thor_clkgen.sv
// testbench clock and reset generator
`timescale 1ns/1ps

module tb_thor_clkgen (
	output logic clk,
	output logic rst_n
);

	initial
	begin
		clk = 1'b0;
		forever #20 clk = ~clk;			// 40 ns period
	end

	// reset held for three rising edges, released off the edge
	initial
	begin
		rst_n = 1'b0;
		repeat (3) @(posedge clk);
		#2 rst_n = 1'b1;
	end

endmodule

// File: thor_alu_checker.sv
// bound assertions on the execute stage valid strobe and result
`timescale 1ns/1ps

module thor_alu_checker (
	input logic clk,
	input logic rst_n,
	input logic issue,
	input thor_alu_pkg::thor_word_t result,
	input logic result_valid
);

	int fail_count = 0;		// assertion failures, summed into the final count

	// no valid strobe while reset is applied
	a_idle_in_reset: assert property (@(posedge clk) !rst_n |-> !result_valid)
	else
	begin
		fail_count++;
		$error("result_valid high while reset is applied");
	end

	// valid is issue delayed by one cycle
	a_valid_after_issue: assert property (@(posedge clk) disable iff (!rst_n)
		issue |=> result_valid)
	else
	begin
		fail_count++;
		$error("issue not followed by result_valid");
	end

	a_no_stray_valid: assert property (@(posedge clk) disable iff (!rst_n)
		!issue |=> !result_valid)
	else
	begin
		fail_count++;
		$error("result_valid without issue the cycle before");
	end

	a_result_known: assert property (@(posedge clk) disable iff (!rst_n)
		result_valid |-> !$isunknown(result))
	else
	begin
		fail_count++;
		$error("result has unknown bits while valid");
	end

endmodule

bind thor_alu_stage thor_alu_checker u_checker (
	.clk(clk),
	.rst_n(rst_n),
	.issue(issue),
	.result(result),
	.result_valid(result_valid)
);

// File: tb_thor_alu.sv
// testbench top, random ops against a reference model, per-test report and timeout
`timescale 1ns/1ps
`include "thor_alu_config.svh"

module tb_thor_alu;

	localparam int N_OPS = 200;			// ops per test
	localparam int MAX_CYCLES = 2000;	// 6 x 200 ops plus short gaps is near 1600
	localparam int K_WORD = 0;
	localparam int K_FLAGS = 1;
	localparam int K_BCD = 2;

	logic clk, rst_n, issue, result_valid;
	logic [7:0] op;
	logic [5:0] fn;
	logic [3:0] insnsz;
	thor_alu_pkg::thor_word_t arg_a, arg_b, arg_c, arg_i, pc, result;
	thor_alu_pkg::thor_word_t held;		// last result seen with valid
	thor_alu_pkg::thor_word_t exp_q[$];	// model values, oldest first
	int kind_q[$];
	string tag_q[$];
	int cycles = 0;
	int errors = 0;
	int checks = 0;
	int tests = 0;

	tb_thor_clkgen u_clkgen (.clk(clk), .rst_n(rst_n));

	thor_alu_stage i_dut (
		.clk(clk),
		.rst_n(rst_n),
		.issue(issue),
		.op(op),
		.fn(fn),
		.arg_a(arg_a),
		.arg_b(arg_b),
		.arg_c(arg_c),
		.arg_i(arg_i),
		.pc(pc),
		.insnsz(insnsz),
		.result(result),
		.result_valid(result_valid)
	);

	// ==============================
	// reference model
	// ==============================
	function automatic logic [15:0] dec_to_bcd(input int v);
		logic [15:0] d;
		d[3:0] = v % 10;
		d[7:4] = (v / 10) % 10;
		d[11:8] = (v / 100) % 10;
		d[15:12] = (v / 1000) % 10;
		return d;
	endfunction

	function automatic thor_alu_pkg::thor_word_t model(input logic [7:0] o,
		input logic [5:0] f, input thor_alu_pkg::thor_word_t a, b, c,
		input thor_alu_pkg::thor_imm_u imm, input thor_alu_pkg::thor_word_t p,
		input logic [3:0] sz);
		thor_alu_pkg::thor_word_t r;
		thor_alu_pkg::thor_word_t mask;
		thor_alu_pkg::thor_flags_t fl;
		int n, da, db;
		r = '0;
		mask = '0;
		fl = '0;
		n = b[5:0];							// shift count
		da = a[7:4] * 10 + a[3:0];			// bcd pairs as decimal
		db = b[7:4] * 10 + b[3:0];
		for (int i = imm.bf.mb; i <= imm.bf.me; i++)
			mask[i] = 1'b1;					// stays empty for mb > me
		case (o)
		`LDI: r = imm.word;
		`RR:
			case (f)
			`ADD: r = a + b;
			`SUB: r = a - b;
			`_2ADDU: r = a * 2 + b;
			`_4ADDU: r = a * 4 + b;
			`_8ADDU: r = a * 8 + b;
			`_16ADDU: r = a * 16 + b;
			`MIN: r = (b < a) ? b : a;
			`MAX: r = (b > a) ? b : a;
			endcase
		`_2ADDUI: r = a * 2 + imm.word;
		`_4ADDUI: r = a * 4 + imm.word;
		`_8ADDUI: r = a * 8 + imm.word;
		`_16ADDUI: r = a * 16 + imm.word;
		`ADDI: r = a + imm.word;
		`SUBI: r = a - imm.word;
		`ANDI: r = a & imm.word;
		`ORI: r = a | imm.word;
		`EORI: r = a ^ imm.word;
		`R:
			case (f)
			`MOV: r = a;
			`NEG: r = 0 - a;
			`NOT: r = ~a;
			`ABS: r = ($signed(a) < 0) ? 0 - a : a;
			`SGN: r = ($signed(a) < 0) ? '1 : ((a != 0) ? 64'd1 : 64'd0);
			default: r = `THOR_BADOP;
			endcase
		`LOGIC:
			case (f)
			`AND: r = a & b;
			`OR: r = a | b;
			`EOR: r = a ^ b;
			`NAND: r = ~(a & b);
			`NOR: r = ~(a | b);
			`ENOR: r = ~(a ^ b);
			`ANDC: r = a & ~b;
			`ORC: r = a | ~b;
			endcase
		`CMP, `CMPI:
		begin
			if (o == `CMPI)
				b = imm.word;				// compare against the immediate
			fl.eq = (a == b);
			fl.lt = ($signed(a) < $signed(b));
			fl.ltu = (a < b);
			r = fl;
		end
		`TST:
			if (f == `ITST)
			begin
				fl.eq = (a == 0);
				fl.lt = ($signed(a) < 0);	// nothing is unsigned below zero
				r = fl;
			end
		`MUX:
			for (int i = 0; i < `THOR_DBW; i++)
				r[i] = a[i] ? b[i] : c[i];
		`JSR: r = p + sz;
		`INT: r = p;
		`BCD:
			case (f)
			`BCDADD: r = dec_to_bcd((da + db) % 100);
			`BCDSUB: r = dec_to_bcd((da - db + 100) % 100);
			`BCDMUL: r = dec_to_bcd(da * db);
			endcase
		`SHIFT:
			case (f)
			`SHL: r = a << n;
			`SHR: r = a >> n;
			`ASR: r = $signed(a) >>> n;
			`ROL: r = (a << n) | (a >> (64 - n));
			`ROR: r = (a >> n) | (a << (64 - n));
			endcase
		`BITFIELD:
			case (f)
			`BFSET: r = a | mask;
			`BFCLR: r = a & ~mask;
			`BFCHG: r = a ^ mask;
			`BFEXTU: r = (a & mask) >> imm.bf.mb;
			endcase
		default: r = `THOR_BADOP;
		endcase
		return r;
	endfunction

	// ==============================
	// compare tasks
	// ==============================
	task automatic check_word(input string tag, input thor_alu_pkg::thor_word_t got,
		input thor_alu_pkg::thor_word_t exp);
		checks++;
		if (got !== exp)
		begin
			errors++;
			$display("FAIL %0t ns %s: word %h, expected %h", $time, tag, got, exp);
		end
	endtask

	task automatic check_flags(input string tag, input thor_alu_pkg::thor_flags_t got,
		input thor_alu_pkg::thor_flags_t exp);
		checks++;
		if (got !== exp)
		begin
			errors++;
			$display("FAIL %0t ns %s: eq %b lt %b ltu %b upper %h, expected eq %b lt %b ltu %b",
				$time, tag, got.eq, got.lt, got.ltu, got.zero, exp.eq, exp.lt, exp.ltu);
		end
	endtask

	task automatic check_bcd(input string tag, input logic [15:0] got, input logic [15:0] exp);
		checks++;
		if (got !== exp)
		begin
			errors++;
			$display("FAIL %0t ns %s: bcd %h, expected %h", $time, tag, got, exp);
		end
	endtask

	// results sampled mid cycle, well away from the capture edge
	always @(negedge clk)
	begin
		if (!rst_n)
		begin
			if (result_valid !== 1'b0)
			begin
				errors++;
				$display("result_valid was high during reset at %0t ns", $time);
			end
		end
		else if (result_valid)
		begin
			if (exp_q.size() == 0)
			begin
				errors++;
				$display("result_valid pulsed at %0t ns with no issue outstanding", $time);
			end
			else if (kind_q[0] == K_FLAGS)
				check_flags(tag_q[0], result, exp_q[0]);
			else if (kind_q[0] == K_BCD)
			begin
				if (result[63:16] !== '0)
				begin
					errors++;
					$display("FAIL %0t ns %s: bcd upper bits %h, expected 0", $time,
						tag_q[0], result[63:16]);
				end
				check_bcd(tag_q[0], result[15:0], exp_q[0][15:0]);
			end
			else
				check_word(tag_q[0], result, exp_q[0]);
			if (exp_q.size() != 0)
			begin
				void'(exp_q.pop_front());
				void'(kind_q.pop_front());
				void'(tag_q.pop_front());
			end
			held = result;
		end
		else if (result !== held)
		begin
			errors++;
			$display("result changed at %0t ns while no result was valid", $time);
		end
	end

	// hard stop on a hung run
	always @(posedge clk)
	begin
		cycles++;
		if (cycles >= MAX_CYCLES)
		begin
			$display("timeout, run not finished after %0d cycles", MAX_CYCLES);
			$display("*** FAILED ***");
			$finish;
		end
	end

	// ==============================
	// stimulus
	// ==============================
	function automatic logic [7:0] bcd_pair();
		logic [3:0] hi, lo;
		hi = $urandom_range(9);
		lo = $urandom_range(9);
		return {hi, lo};
	endfunction

	task automatic pick_op(input int which, output logic [7:0] o, output logic [5:0] f,
		output int kind);
		int r;
		r = $urandom_range(15);
		f = $urandom_range(7);
		kind = K_WORD;
		case (which)
		1: o = f[0] ? `LDI : `RR;
		2:
			case (r)
			0, 1, 2: o = `RR;
			3, 4: o = `LOGIC;
			5, 6: o = `R;
			7: o = `LDI;
			8: o = `ADDI;
			9: o = `SUBI;
			10: o = `ANDI;
			11: o = `ORI;
			12: o = `EORI;
			13: o = f[0] ? `_2ADDUI : `_4ADDUI;
			14: o = f[0] ? `_8ADDUI : `_16ADDUI;
			default: o = {f[1:0], 6'h3F};	// 3F, 7F, BF, FF are all unused
			endcase
		3:
		begin
			o = (r < 6) ? `CMP : ((r < 12) ? `CMPI : `TST);
			f = (r == 15) ? 6'd1 : `ITST;	// odd test code gives zero flags
			kind = K_FLAGS;
		end
		4:
		begin
			o = r[0] ? `SHIFT : `BITFIELD;
			f = r[0] ? 6'($urandom_range(4)) : ((f[1:0] == 2'd3) ? `BFEXTU : {4'd0, f[1:0]});
		end
		5:
		begin
			o = `BCD;
			f = $urandom_range(2);
			kind = K_BCD;
		end
		default: o = (r < 5) ? `JSR : ((r < 10) ? `INT : `MUX);
		endcase
		if ((o == `RR) && (f == 6'd2))
			f = `MIN;
		if ((o == `RR) && (f == 6'd3))
			f = `MAX;
		if (o == `R)
			f = $urandom_range(5);			// 5 is an unknown unary code
	endtask

	task automatic drive_op(input logic [7:0] o, input logic [5:0] f, input int kind);
		thor_alu_pkg::thor_imm_u imm;
		op = o;
		fn = f;
		arg_a = {$urandom, $urandom};
		arg_b = {$urandom, $urandom};
		arg_c = {$urandom, $urandom};
		arg_i = {$urandom, $urandom};
		pc = {$urandom, $urandom};
		insnsz = $urandom_range(15);
		if (o == `BCD)
		begin
			arg_a[7:0] = bcd_pair();
			arg_b[7:0] = bcd_pair();
		end
		else if ((o == `CMP) && ($urandom_range(3) == 0))
			arg_b = arg_a;					// hit the equal case
		else if ((o == `CMPI) && ($urandom_range(3) == 0))
			arg_i = arg_a;
		else if ((o == `TST) && ($urandom_range(3) == 0))
			arg_a = '0;
		imm.word = arg_i;
		exp_q.push_back(model(o, f, arg_a, arg_b, arg_c, imm, pc, insnsz));
		kind_q.push_back(kind);
		tag_q.push_back($sformatf("op %02h fn %0d", o, f));
		issue = 1'b1;
		@(posedge clk);
		#2;
		issue = 1'b0;						// next call raises it again
	endtask

	task automatic run_test(input int which, input string name);
		int err0, chk0, kind, waited;
		logic [7:0] o;
		logic [5:0] f;
		err0 = errors;
		chk0 = checks;
		for (int n = 0; n < N_OPS; n++)
		begin
			pick_op(which, o, f, kind);
			drive_op(o, f, kind);
			if ($urandom_range(4) == 0)
				repeat ($urandom_range(2, 1))
				begin
					@(posedge clk);
					#2;
				end
		end
		waited = 0;
		while ((exp_q.size() != 0) && (waited < 4))
		begin
			@(posedge clk);
			#2;
			waited++;
		end
		if (exp_q.size() != 0)
		begin
			errors += exp_q.size();
			$display("%0d results of test %s never arrived", exp_q.size(), name);
			exp_q.delete();
			kind_q.delete();
			tag_q.delete();
		end
		tests++;
		$display("test %0d %-14s %0d checks, %0d errors", which, name, checks - chk0,
			errors - err0);
	endtask

	initial
	begin
		void'($urandom(11409));				// seed the generator once
		issue = 1'b0;
		op = '0;
		fn = '0;
		arg_a = '0;
		arg_b = '0;
		arg_c = '0;
		arg_i = '0;
		pc = '0;
		insnsz = '0;
		held = '0;
		@(posedge rst_n);
		repeat (3)
		begin
			@(posedge clk);
			#2;								// idle, no valid expected
		end
		run_test(1, "reset_timing");
		run_test(2, "arith_logic");
		run_test(3, "flags");
		run_test(4, "shift_bitfield");
		run_test(5, "bcd");
		run_test(6, "ctrl_mux");
		errors += i_dut.u_checker.fail_count;
		$display("done: %0d tests, %0d checks, %0d errors", tests, checks, errors);
		if (errors == 0)
			$display("*** PASSED ***");
		else
			$display("*** FAILED ***");
		$finish;
	end

endmodule

// File: thor_alu.f
+incdir+.
thor_alu_pkg.sv
thor_alu_if.sv
thor_shifter.sv
thor_bcd_unit.sv
thor_bitfield.sv
thor_alu.sv
thor_alu_stage.sv
tb_thor_clkgen.sv
thor_alu_checker.sv
tb_thor_alu.sv
